// ==== sources.f ====
+incdir+hdl
hdl/camera_spi_pkg.sv
hdl/camera_spi_if.sv
hdl/spi_peripheral.sv
hdl/spi_registers.sv
hdl/image_buffer.sv
hdl/metering.sv
hdl/camera_spi_top.sv
test/camera_spi_asserts.sv
test/camera_spi_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= camera_spi_tb
FILE_LIST ?= sources.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VERILATOR_FLAGS ?= --binary --timing --assert -Wno-fatal
FAIL_MESSAGE ?= Simulation failed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"

test:
	$(VERILATOR) $(VERILATOR_FLAGS) --top-module $(TOP) -f $(FILE_LIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MESSAGE)" $(LOG); then \
		echo "Test run reported failure, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== test/camera_spi_tb.sv ====
`include "camera_spi_defines.svh"

module camera_spi_tb;

    localparam int PIXEL_COUNT = `IMAGE_BUFFER_DEPTH;
    localparam int SPI_HALF_PERIOD = 10;
    localparam int BYTE_CYCLES = 16 * SPI_HALF_PERIOD;
    localparam int FRAME_CYCLES = PIXEL_COUNT + 8;
    localparam int WATCHDOG_CYCLES = 3 * FRAME_CYCLES + 400 * BYTE_CYCLES;

    logic clock_in;
    logic reset_n_in;
    logic spi_clock;
    logic spi_select_n;
    logic spi_mosi;
    logic spi_miso;
    logic [7:0] pixel_red;
    logic [7:0] pixel_green;
    logic [7:0] pixel_blue;
    logic pixel_valid;
    logic frame_start;
    logic frame_end;
    logic start_capture;
    logic [9:0] resolution;
    logic [1:0] compression_factor;
    logic power_save_enable;

    integer seed;
    int error_count;
    int check_count;
    int capture_pulses;
    logic [7:0] frame_red [PIXEL_COUNT];
    logic [7:0] frame_green [PIXEL_COUNT];
    logic [7:0] frame_blue [PIXEL_COUNT];
    logic [7:0] captured_gray [PIXEL_COUNT];
    logic [7:0] rx_queue [$];

    camera_spi_top u_camera_spi_top (
        .clock_in(clock_in),
        .reset_n_in(reset_n_in),
        .spi_clock(spi_clock),
        .spi_select_n(spi_select_n),
        .spi_mosi(spi_mosi),
        .spi_miso(spi_miso),
        .pixel_red(pixel_red),
        .pixel_green(pixel_green),
        .pixel_blue(pixel_blue),
        .pixel_valid(pixel_valid),
        .frame_start(frame_start),
        .frame_end(frame_end),
        .start_capture(start_capture),
        .resolution(resolution),
        .compression_factor(compression_factor),
        .power_save_enable(power_save_enable)
    );

    initial begin
        clock_in = 1'b0;
        forever #20 clock_in = ~clock_in;
    end

    // Count capture pulses in the middle of each cycle
    always @(negedge clock_in) begin
        if (start_capture === 1'b1) begin
            capture_pulses++;
        end
    end

    // Inputs change 5 units after the rising edge
    task automatic wait_cycles(input int count);
        repeat (count) @(posedge clock_in);
        #5;
    endtask

    // Mode 0, MSB first, miso sampled just before each rising edge
    task automatic spi_transfer(input logic [7:0] tx, output logic [7:0] rx);
        for (int i = 7; i >= 0; i--) begin
            spi_mosi = tx[i];
            wait_cycles(SPI_HALF_PERIOD);
            rx[i] = spi_miso;
            spi_clock = 1'b1;
            wait_cycles(SPI_HALF_PERIOD);
            spi_clock = 1'b0;
        end
    endtask

    // Opcode then length operand bytes, the rest padded with zero
    task automatic spi_command(input logic [7:0] opcode, input int length,
                               input logic [7:0] first, input logic [7:0] second);
        logic [7:0] tx;
        logic [7:0] rx;
        rx_queue.delete();
        spi_select_n = 1'b0;
        for (int n = 0; n <= length; n++) begin
            case (n)
                0: tx = opcode;
                1: tx = first;
                2: tx = second;
                default: tx = 8'h00;
            endcase
            spi_transfer(tx, rx);
            rx_queue.push_back(rx);
        end
        wait_cycles(SPI_HALF_PERIOD);
        spi_select_n = 1'b1;
        wait_cycles(SPI_HALF_PERIOD);
    endtask

    task automatic send_frame();
        frame_start = 1'b1;
        wait_cycles(1);
        frame_start = 1'b0;
        for (int i = 0; i < PIXEL_COUNT; i++) begin
            frame_red[i] = 8'($random(seed));
            frame_green[i] = 8'($random(seed));
            frame_blue[i] = 8'($random(seed));
            pixel_red = frame_red[i];
            pixel_green = frame_green[i];
            pixel_blue = frame_blue[i];
            pixel_valid = 1'b1;
            wait_cycles(1);
        end
        pixel_valid = 1'b0;
        frame_end = 1'b1;
        wait_cycles(1);
        frame_end = 1'b0;
        wait_cycles(2);
    endtask

    // Weighted gray, green counts twice
    function automatic logic [7:0] gray_of(input int index);
        int sum;
        sum = frame_red[index] + 2 * frame_green[index] + frame_blue[index];
        return 8'(sum / 4);
    endfunction

    // 0..2 centre red, green, blue; 3..5 whole-frame averages
    function automatic logic [7:0] meter_of(input int select);
        int sum;
        int count;
        int x;
        int y;
        logic [7:0] value;
        sum = 0;
        count = 0;
        for (int i = 0; i < PIXEL_COUNT; i++) begin
            x = i % `FRAME_WIDTH;
            y = i / `FRAME_WIDTH;
            case (select % 3)
                0: value = frame_red[i];
                1: value = frame_green[i];
                default: value = frame_blue[i];
            endcase
            if (select >= 3 ||
                (x >= `FRAME_WIDTH / 4 && x < 3 * `FRAME_WIDTH / 4 &&
                 y >= `FRAME_HEIGHT / 4 && y < 3 * `FRAME_HEIGHT / 4)) begin
                sum += value;
                count++;
            end
        end
        return 8'(sum / count);
    endfunction

    task automatic check_byte(input string name, input logic [7:0] expected,
                              input logic [7:0] actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("FAIL %s: expected 0x%02h, actual 0x%02h", name, expected, actual);
        end
    endtask

    task automatic check_resolution(input string name, input logic [9:0] expected,
                                    input logic [9:0] actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("FAIL %s: expected 0x%03h, actual 0x%03h", name, expected, actual);
        end
    endtask

    task automatic check_compression(input string name, input logic [1:0] expected,
                                     input logic [1:0] actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("FAIL %s: expected %0d, actual %0d", name, expected, actual);
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("FAIL %s: expected %b, actual %b", name, expected, actual);
        end
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clock_in);
        $display("Watchdog expired after %0d clock cycles", WATCHDOG_CYCLES);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        seed = 32'h1daa9af1;
        error_count = 0;
        check_count = 0;
        capture_pulses = 0;
        reset_n_in = 1'b0;
        spi_clock = 1'b0;
        spi_select_n = 1'b1;
        spi_mosi = 1'b0;
        pixel_red = 8'h00;
        pixel_green = 8'h00;
        pixel_blue = 8'h00;
        pixel_valid = 1'b0;
        frame_start = 1'b0;
        frame_end = 1'b0;
        wait_cycles(4);
        reset_n_in = 1'b1;
        wait_cycles(4);

        // Idle state after reset
        check_flag("start_capture after reset", 1'b0, start_capture);
        check_resolution("resolution after reset", 10'h000, resolution);
        check_compression("compression after reset", 2'd0, compression_factor);
        check_flag("power save after reset", 1'b0, power_save_enable);
        check_flag("spi_miso after reset", 1'b0, spi_miso);
        spi_command(camera_spi_pkg::OPCODE_IMAGE_READY, 1, 8'h00, 8'h00);
        check_byte("image ready after reset", 8'h00, rx_queue[1]);
        spi_command(camera_spi_pkg::OPCODE_BYTES_AVAILABLE, 2, 8'h00, 8'h00);
        check_byte("bytes available high after reset", 8'h00, rx_queue[1]);
        check_byte("bytes available low after reset", 8'h00, rx_queue[2]);

        spi_command(camera_spi_pkg::OPCODE_ZOOM, 2, 8'h02, 8'h5a);
        check_resolution("zoom resolution", 10'h25a, resolution);
        spi_command(camera_spi_pkg::OPCODE_COMPRESSION, 1, 8'h03, 8'h00);
        check_compression("compression factor", 2'd3, compression_factor);
        spi_command(camera_spi_pkg::OPCODE_POWER_SAVE, 1, 8'h01, 8'h00);
        check_flag("power save enable", 1'b1, power_save_enable);

        // Metering of an uncaptured frame
        send_frame();
        spi_command(camera_spi_pkg::OPCODE_METERING, 6, 8'h00, 8'h00);
        for (int k = 0; k < 6; k++) begin
            check_byte($sformatf("metering byte %0d", k), meter_of(k), rx_queue[k + 1]);
        end

        // Captured frame read back in order
        spi_command(camera_spi_pkg::OPCODE_CAPTURE, 0, 8'h00, 8'h00);
        check_flag("single start_capture pulse", 1'b1, capture_pulses == 1);
        send_frame();
        spi_command(camera_spi_pkg::OPCODE_IMAGE_READY, 1, 8'h00, 8'h00);
        check_byte("image ready after capture", 8'h01, rx_queue[1]);
        spi_command(camera_spi_pkg::OPCODE_BYTES_AVAILABLE, 2, 8'h00, 8'h00);
        check_byte("bytes available high after capture", 8'h01, rx_queue[1]);
        check_byte("bytes available low after capture", 8'h00, rx_queue[2]);
        spi_command(camera_spi_pkg::OPCODE_READ_DATA, PIXEL_COUNT, 8'h00, 8'h00);
        for (int i = 0; i < PIXEL_COUNT; i++) begin
            captured_gray[i] = gray_of(i);
            check_byte($sformatf("read data %0d", i), captured_gray[i], rx_queue[i + 1]);
        end

        // Reading past the end holds the pointer
        spi_command(camera_spi_pkg::OPCODE_READ_DATA, 10, 8'h00, 8'h00);
        spi_command(camera_spi_pkg::OPCODE_BYTES_AVAILABLE, 2, 8'h00, 8'h00);
        check_byte("bytes available high after overread", 8'h00, rx_queue[1]);
        check_byte("bytes available low after overread", 8'h00, rx_queue[2]);

        // Frame without capture must not touch the buffer
        send_frame();
        spi_command(camera_spi_pkg::OPCODE_IMAGE_READY, 1, 8'h00, 8'h00);
        check_byte("image ready after unarmed frame", 8'h01, rx_queue[1]);
        spi_command(camera_spi_pkg::OPCODE_BYTES_AVAILABLE, 2, 8'h00, 8'h00);
        check_byte("bytes available high after unarmed frame", 8'h00, rx_queue[1]);
        check_byte("bytes available low after unarmed frame", 8'h00, rx_queue[2]);
        for (int i = 0; i < PIXEL_COUNT; i++) begin
            check_byte($sformatf("buffer byte %0d kept", i), captured_gray[i],
                       u_camera_spi_top.u_image_buffer.memory[i]);
        end
        check_flag("no further start_capture pulse", 1'b1, capture_pulses == 1);

        $display("Checks run: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== test/camera_spi_asserts.sv ====
`include "camera_spi_defines.svh"

module camera_spi_asserts (
    input logic clock_in,
    input logic reset_n_in,
    input logic start_capture,
    input logic op_code_valid,
    input logic operand_valid,
    input logic [`IMAGE_SIZE_WIDTH-1:0] image_address,
    input logic [`IMAGE_SIZE_WIDTH-1:0] image_total_size
);

    // Capture request is a single pulse
    capture_single_pulse: assert property (
        @(posedge clock_in) disable iff (!reset_n_in)
        start_capture |=> !start_capture
    ) else $error("start_capture stayed high for more than one cycle");

    operand_needs_opcode: assert property (
        @(posedge clock_in) disable iff (!reset_n_in)
        operand_valid |-> op_code_valid
    ) else $error("operand_valid pulsed without op_code_valid");

    address_within_frame: assert property (
        @(posedge clock_in) disable iff (!reset_n_in)
        image_address <= image_total_size
    ) else $error("image address went past the stored frame size");

endmodule

// Register block sees the strobes, the capture pulse and the read pointer
bind spi_registers camera_spi_asserts u_registers_asserts (
    .clock_in(clock_in),
    .reset_n_in(reset_n_in),
    .start_capture(image.start_capture),
    .op_code_valid(bus.op_code_valid),
    .operand_valid(bus.operand_valid),
    .image_address(image.image_address),
    .image_total_size(image.image_total_size)
);

// ==== hdl/camera_spi_top.sv ====
module camera_spi_top (
    input logic clock_in,
    input logic reset_n_in,

    input logic spi_clock,
    input logic spi_select_n,
    input logic spi_mosi,
    output logic spi_miso,

    input logic [7:0] pixel_red,
    input logic [7:0] pixel_green,
    input logic [7:0] pixel_blue,
    input logic pixel_valid,
    input logic frame_start,
    input logic frame_end,

    output logic start_capture,
    output logic [9:0] resolution,
    output logic [1:0] compression_factor,
    output logic power_save_enable
);

    register_bus_if bus ();
    image_read_if image ();
    metering_if meter ();

    spi_peripheral u_spi_peripheral (
        .clock_in(clock_in),
        .reset_n_in(reset_n_in),
        .spi_clock(spi_clock),
        .spi_select_n(spi_select_n),
        .spi_mosi(spi_mosi),
        .spi_miso(spi_miso),
        .bus(bus.peripheral)
    );

    spi_registers u_spi_registers (
        .clock_in(clock_in),
        .reset_n_in(reset_n_in),
        .bus(bus.registers),
        .image(image.registers),
        .meter(meter.registers),
        .resolution(resolution),
        .compression_factor(compression_factor),
        .power_save_enable(power_save_enable)
    );

    // Buffer and meter see the same pixel stream
    image_buffer u_image_buffer (
        .clock_in(clock_in),
        .reset_n_in(reset_n_in),
        .pixel_red(pixel_red),
        .pixel_green(pixel_green),
        .pixel_blue(pixel_blue),
        .pixel_valid(pixel_valid),
        .frame_start(frame_start),
        .frame_end(frame_end),
        .image(image.buffer)
    );

    metering u_metering (
        .clock_in(clock_in),
        .reset_n_in(reset_n_in),
        .pixel_red(pixel_red),
        .pixel_green(pixel_green),
        .pixel_blue(pixel_blue),
        .pixel_valid(pixel_valid),
        .frame_start(frame_start),
        .frame_end(frame_end),
        .meter(meter.meter)
    );

    assign start_capture = image.start_capture;

endmodule

// ==== hdl/metering.sv ====
`include "camera_spi_defines.svh"

module metering (
    input logic clock_in,
    input logic reset_n_in,
    input logic [7:0] pixel_red,
    input logic [7:0] pixel_green,
    input logic [7:0] pixel_blue,
    input logic pixel_valid,
    input logic frame_start,
    input logic frame_end,
    metering_if.meter meter
);

    localparam int X_WIDTH = $clog2(`FRAME_WIDTH);
    localparam int Y_WIDTH = $clog2(`FRAME_HEIGHT);
    localparam int AREA_LOG2 = X_WIDTH + Y_WIDTH;
    localparam int SUM_WIDTH = 8 + AREA_LOG2;

    logic [X_WIDTH-1:0] x_position;
    logic [Y_WIDTH-1:0] y_position;
    logic in_center;

    // Index 0 red, 1 green, 2 blue
    logic [7:0] pixel [3];
    logic [SUM_WIDTH-1:0] frame_sum [3];
    logic [SUM_WIDTH-1:0] center_sum [3];
    logic [7:0] frame_average [3];
    logic [7:0] center_average [3];

    assign pixel[0] = pixel_red;
    assign pixel[1] = pixel_green;
    assign pixel[2] = pixel_blue;

    // Middle half of each axis: top two bits are 01 or 10
    assign in_center = (x_position[X_WIDTH-1] ^ x_position[X_WIDTH-2]) &
                       (y_position[Y_WIDTH-1] ^ y_position[Y_WIDTH-2]);

    always_ff @(posedge clock_in) begin
        if (!reset_n_in || frame_start) begin
            x_position <= '0;
            y_position <= '0;
        end else if (pixel_valid) begin
            x_position <= x_position + 1'b1;
            if (&x_position) begin
                y_position <= y_position + 1'b1;
            end
        end
    end

    always_ff @(posedge clock_in) begin
        for (int c = 0; c < 3; c++) begin
            if (frame_start) begin
                frame_sum[c] <= '0;
                center_sum[c] <= '0;
            end else if (pixel_valid) begin
                frame_sum[c] <= frame_sum[c] + SUM_WIDTH'(pixel[c]);
                if (in_center) begin
                    center_sum[c] <= center_sum[c] + SUM_WIDTH'(pixel[c]);
                end
            end
        end
    end

    // Centre window holds a quarter of the frame
    always_ff @(posedge clock_in) begin
        for (int c = 0; c < 3; c++) begin
            if (!reset_n_in) begin
                frame_average[c] <= 8'h00;
                center_average[c] <= 8'h00;
            end else if (frame_end) begin
                frame_average[c] <= 8'(frame_sum[c] >> AREA_LOG2);
                center_average[c] <= 8'(center_sum[c] >> (AREA_LOG2 - 2));
            end
        end
    end

    assign meter.red_center = center_average[0];
    assign meter.green_center = center_average[1];
    assign meter.blue_center = center_average[2];
    assign meter.red_average = frame_average[0];
    assign meter.green_average = frame_average[1];
    assign meter.blue_average = frame_average[2];

endmodule

// ==== hdl/image_buffer.sv ====
`include "camera_spi_defines.svh"

module image_buffer (
    input logic clock_in,
    input logic reset_n_in,
    input logic [7:0] pixel_red,
    input logic [7:0] pixel_green,
    input logic [7:0] pixel_blue,
    input logic pixel_valid,
    input logic frame_start,
    input logic frame_end,
    image_read_if.buffer image
);

    localparam int ADDRESS_BITS = $clog2(`IMAGE_BUFFER_DEPTH);
    localparam logic [`IMAGE_SIZE_WIDTH-1:0] DEPTH = `IMAGE_BUFFER_DEPTH;

    logic [7:0] memory [`IMAGE_BUFFER_DEPTH];
    logic [`IMAGE_SIZE_WIDTH-1:0] write_count;
    logic [9:0] gray_sum;
    logic armed;
    logic writing;
    logic write_enable;

    // (r + 2g + b) / 4
    assign gray_sum = {2'b00, pixel_red} + {1'b0, pixel_green, 1'b0} + {2'b00, pixel_blue};
    assign write_enable = writing && pixel_valid && write_count < DEPTH;

    always_ff @(posedge clock_in) begin
        if (!reset_n_in) begin
            armed <= 1'b0;
            writing <= 1'b0;
            write_count <= '0;
            image.image_ready <= 1'b0;
            image.image_total_size <= '0;
        end else if (image.start_capture) begin
            armed <= 1'b1;
            writing <= 1'b0;
            image.image_ready <= 1'b0;
            image.image_total_size <= '0;
        end else if (armed && frame_start) begin
            armed <= 1'b0;
            writing <= 1'b1;
            write_count <= '0;
        end else if (writing && frame_end) begin
            writing <= 1'b0;
            image.image_ready <= 1'b1;
            image.image_total_size <= write_count;
        end else if (write_enable) begin
            write_count <= write_count + 1'b1;
        end
    end

    always_ff @(posedge clock_in) begin
        if (write_enable) begin
            memory[write_count[ADDRESS_BITS-1:0]] <= gray_sum[9:2];
        end
        image.image_data <= memory[image.image_address[ADDRESS_BITS-1:0]];
    end

endmodule

// ==== hdl/spi_registers.sv ====
`include "camera_spi_defines.svh"

module spi_registers (
    input logic clock_in,
    input logic reset_n_in,
    register_bus_if.registers bus,
    image_read_if.registers image,
    metering_if.registers meter,
    output logic [9:0] resolution,
    output logic [1:0] compression_factor,
    output logic power_save_enable
);

    logic [`IMAGE_SIZE_WIDTH-1:0] bytes_remaining;
    logic op_code_valid_last;

    assign bytes_remaining = image.image_total_size - image.image_address;

    always_ff @(posedge clock_in) begin
        if (!reset_n_in) begin
            bus.response <= 8'h00;
            bus.response_valid <= 1'b0;
            image.start_capture <= 1'b0;
            image.image_address <= '0;
            resolution <= 10'd0;
            compression_factor <= 2'd0;
            power_save_enable <= 1'b0;
            op_code_valid_last <= 1'b0;
        end else begin
            op_code_valid_last <= bus.op_code_valid;
            bus.response_valid <= 1'b0;
            image.start_capture <= 1'b0;

            if (bus.op_code_valid) begin
                case (bus.op_code)
                    camera_spi_pkg::OPCODE_CAPTURE: begin
                        // Single pulse on the rising edge of the opcode level
                        if (!op_code_valid_last) begin
                            image.start_capture <= 1'b1;
                            image.image_address <= '0;
                        end
                    end

                    // Big-endian byte count still to read
                    camera_spi_pkg::OPCODE_BYTES_AVAILABLE: begin
                        case (bus.operand_count)
                            0: bus.response <= bytes_remaining[`IMAGE_SIZE_WIDTH-1 -: 8];
                            1: bus.response <= bytes_remaining[7:0];
                            default: bus.response <= 8'h00;
                        endcase
                        bus.response_valid <= 1'b1;
                    end

                    camera_spi_pkg::OPCODE_READ_DATA: begin
                        bus.response <= image.image_data;
                        bus.response_valid <= 1'b1;

                        // Pointer stops at the end of the stored frame
                        if (bus.operand_valid &&
                            image.image_address < image.image_total_size) begin
                            image.image_address <= image.image_address + 1'b1;
                        end
                    end

                    camera_spi_pkg::OPCODE_ZOOM: begin
                        if (bus.operand_valid) begin
                            case (bus.operand_count)
                                0: resolution <= {bus.operand[1:0], 8'h00};
                                1: resolution <= {resolution[9:8], bus.operand};
                                default: resolution <= resolution;
                            endcase
                        end
                    end

                    camera_spi_pkg::OPCODE_METERING: begin
                        case (bus.operand_count)
                            0: bus.response <= meter.red_center;
                            1: bus.response <= meter.green_center;
                            2: bus.response <= meter.blue_center;
                            3: bus.response <= meter.red_average;
                            4: bus.response <= meter.green_average;
                            5: bus.response <= meter.blue_average;
                            default: bus.response <= 8'h00;
                        endcase
                        bus.response_valid <= 1'b1;
                    end

                    camera_spi_pkg::OPCODE_COMPRESSION: begin
                        if (bus.operand_valid) begin
                            compression_factor <= bus.operand[1:0];
                        end
                    end

                    camera_spi_pkg::OPCODE_IMAGE_READY: begin
                        bus.response <= {7'b0, image.image_ready};
                        bus.response_valid <= 1'b1;
                    end

                    camera_spi_pkg::OPCODE_POWER_SAVE: begin
                        if (bus.operand_valid) begin
                            power_save_enable <= bus.operand[0];
                        end
                    end

                    default: begin
                        bus.response_valid <= 1'b0;
                    end
                endcase
            end
        end
    end

endmodule

// ==== hdl/spi_peripheral.sv ====
module spi_peripheral (
    input logic clock_in,
    input logic reset_n_in,
    input logic spi_clock,
    input logic spi_select_n,
    input logic spi_mosi,
    output logic spi_miso,
    register_bus_if.peripheral bus
);

    // Two sync flops plus one history flop for edge detection
    logic [2:0] clock_sync;
    logic [1:0] select_sync;
    logic [1:0] mosi_sync;

    logic spi_rise;
    logic spi_fall;
    logic selected;

    logic [2:0] bit_count;
    logic [7:0] shift_in;
    logic [7:0] shift_out;
    logic [7:0] byte_in;
    camera_spi_pkg::spi_phase_t phase;

    always_ff @(posedge clock_in) begin
        if (!reset_n_in) begin
            clock_sync <= 3'b000;
            select_sync <= 2'b11;
        end else begin
            clock_sync <= {clock_sync[1:0], spi_clock};
            select_sync <= {select_sync[0], spi_select_n};
        end
    end

    always_ff @(posedge clock_in) begin
        mosi_sync <= {mosi_sync[0], spi_mosi};
    end

    assign spi_rise = clock_sync[1] & ~clock_sync[2];
    assign spi_fall = ~clock_sync[1] & clock_sync[2];
    assign selected = ~select_sync[1];

    // Byte as it stands after the current rising edge
    assign byte_in = {shift_in[6:0], mosi_sync[1]};

    assign spi_miso = shift_out[7];

    always_ff @(posedge clock_in) begin
        if (!reset_n_in) begin
            phase <= camera_spi_pkg::PHASE_OPCODE;
            bit_count <= 3'd0;
            shift_out <= 8'h00;
            bus.op_code_valid <= 1'b0;
            bus.operand_valid <= 1'b0;
            bus.operand_count <= '0;
        end else begin
            bus.operand_valid <= 1'b0;

            if (!selected) begin
                phase <= camera_spi_pkg::PHASE_OPCODE;
                bit_count <= 3'd0;
                shift_out <= 8'h00;
                bus.op_code_valid <= 1'b0;
                bus.operand_count <= '0;
            end else begin
                // Count advances after each operand pulse, saturating
                if (bus.operand_valid && bus.operand_count != '1) begin
                    bus.operand_count <= bus.operand_count + 1'b1;
                end

                if (spi_rise) begin
                    shift_in <= byte_in;
                    bit_count <= bit_count + 3'd1;

                    if (bit_count == 3'd7) begin
                        if (phase == camera_spi_pkg::PHASE_OPCODE) begin
                            bus.op_code <= byte_in;
                            bus.op_code_valid <= 1'b1;
                            phase <= camera_spi_pkg::PHASE_OPERAND;
                        end else begin
                            bus.operand <= byte_in;
                            bus.operand_valid <= 1'b1;
                        end
                    end
                end

                // Load the response at a byte boundary, else shift out MSB first
                if (spi_fall) begin
                    if (bit_count == 3'd0) begin
                        shift_out <= bus.response_valid ? bus.response : 8'h00;
                    end else begin
                        shift_out <= {shift_out[6:0], 1'b0};
                    end
                end
            end
        end
    end

endmodule

// ==== hdl/camera_spi_if.sv ====
`include "camera_spi_defines.svh"

// Strobes between the SPI peripheral and the register block
interface register_bus_if;
    logic [7:0] op_code;
    logic op_code_valid;
    logic [7:0] operand;
    logic operand_valid;
    logic [`OPERAND_COUNT_WIDTH-1:0] operand_count;
    logic [7:0] response;
    logic response_valid;

    modport peripheral (
        output op_code, op_code_valid, operand, operand_valid, operand_count,
        input response, response_valid
    );

    modport registers (
        input op_code, op_code_valid, operand, operand_valid, operand_count,
        output response, response_valid
    );
endinterface

// Frame store access
interface image_read_if;
    logic image_ready;
    logic [`IMAGE_SIZE_WIDTH-1:0] image_total_size;
    logic [7:0] image_data;
    logic [`IMAGE_SIZE_WIDTH-1:0] image_address;
    logic start_capture;

    modport buffer (
        output image_ready, image_total_size, image_data,
        input image_address, start_capture
    );

    modport registers (
        input image_ready, image_total_size, image_data,
        output image_address, start_capture
    );
endinterface

// Per-frame metering results
interface metering_if;
    logic [7:0] red_center;
    logic [7:0] green_center;
    logic [7:0] blue_center;
    logic [7:0] red_average;
    logic [7:0] green_average;
    logic [7:0] blue_average;

    modport meter (
        output red_center, green_center, blue_center,
        output red_average, green_average, blue_average
    );

    modport registers (
        input red_center, green_center, blue_center,
        input red_average, green_average, blue_average
    );
endinterface

// ==== hdl/camera_spi_pkg.sv ====
package camera_spi_pkg;

    // Opcodes sent as the first byte of a select period
    typedef enum logic [7:0] {
        OPCODE_CAPTURE         = 8'h20,
        OPCODE_BYTES_AVAILABLE = 8'h21,
        OPCODE_READ_DATA       = 8'h22,
        OPCODE_ZOOM            = 8'h23,
        OPCODE_METERING        = 8'h25,
        OPCODE_COMPRESSION     = 8'h26,
        OPCODE_IMAGE_READY     = 8'h27,
        OPCODE_POWER_SAVE      = 8'h28
    } register_opcode_t;

    // Which byte of the transfer is being shifted in
    typedef enum logic {
        PHASE_OPCODE  = 1'b0,
        PHASE_OPERAND = 1'b1
    } spi_phase_t;

endpackage

// ==== hdl/camera_spi_defines.svh ====
`ifndef CAMERA_SPI_DEFINES_SVH
`define CAMERA_SPI_DEFINES_SVH

// Frame geometry, both powers of two
`define FRAME_WIDTH 16
`define FRAME_HEIGHT 16

// One gray byte per pixel
`define IMAGE_BUFFER_DEPTH (`FRAME_WIDTH * `FRAME_HEIGHT)

// Total size and image address
`define IMAGE_SIZE_WIDTH 16

// Saturating operand counter
`define OPERAND_COUNT_WIDTH 8

`endif
